/* Bender.yml */
package:
  name: writeback

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_data_pkg.sv
      - hdl/wb_ctrl_pkg.sv
      - hdl/wb_steer.sv
      - hdl/wb_branch.sv
      - hdl/wb_regfile.sv
      - hdl/wbaq.sv
      - hdl/writeback_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/writeback_tb.sv

/* bench/writeback_tb.sv */
`timescale 1ns/1ps
`include "wb_defines.svh"

module writeback_tb
    import wb_data_pkg::*;
    import wb_ctrl_pkg::*;
();

    localparam int wait_limit = 40;   // cycles before a wait gives up

    logic                 clk;
    logic                 reset;
    logic                 valid_in;
    wb_data_t             inp1;
    wb_data_t             inp2;
    wb_data_t             inp3;
    wb_data_t             inp4;
    wb_addr_t             inp1_dest;
    wb_addr_t             inp2_dest;
    wb_addr_t             inp3_dest;
    wb_addr_t             inp4_dest;
    logic [`WB_SLOTS-1:0] is_reg;
    logic [`WB_SLOTS-1:0] is_seg;
    logic [`WB_SLOTS-1:0] is_mem;
    wb_size_t             inp_size;
    logic                 far_xfer;
    logic                 br_valid_in;
    logic                 br_taken_in;
    logic                 br_correct_in;
    fip_t                 br_fip_in;
    fip_t                 br_fip_p1_in;
    fip_t                 eip_in;
    logic                 ie_in;
    ie_type_t             ie_type_in;
    logic                 interrupt_in;
    logic                 mem_ack;
    reg_idx_t             rd_gpr_idx;
    reg_idx_t             rd_seg_idx;
    logic                 valid_out;
    logic                 stall;
    logic                 wbaq_full;
    logic                 mem_req;
    wb_addr_t             mem_req_addr;
    wb_data_t             mem_req_data;
    wb_size_t             mem_req_size;
    fip_t                 new_eip;
    fip_t                 fip_e;
    fip_t                 fip_o;
    logic                 is_resteer;
    seg_t                 cs_out;
    logic                 final_ie_val;
    ie_type_t             final_ie_type;
    logic [31:0]          rd_gpr_data;
    seg_t                 rd_seg_data;

    wb_data_t        slot_val  [`WB_SLOTS];
    wb_addr_t        slot_dest [`WB_SLOTS];
    wb_addr_t        exp_addr  [$];   // stores still owed by the queue
    wb_data_t        exp_data  [$];
    wb_size_t        exp_size  [$];
    logic [63:0]     fld       [11];  // numeric fields of the current data line
    integer          seed;
    integer          errors;
    integer          test_errors;
    integer          tests;
    integer          failed_tests;
    logic            abort;
    logic [8*24-1:0] test_name;

    writeback_top u_dut (.*);

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        test_errors++;
        $display("error at %0t: %0s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic timeout_failure(input string what);
        errors++;
        test_errors++;
        abort = 1'b1;
        $display("timeout at %0t: %0s", $time, what);
    endtask

    task automatic set_slot(input int n, input logic [2:0] tag, input wb_addr_t dest,
                            input wb_data_t value);
        is_reg[n-1]    = tag[0];
        is_seg[n-1]    = tag[1];
        is_mem[n-1]    = tag[2];
        slot_dest[n-1] = dest;
        slot_val[n-1]  = value;
        inp1      = slot_val[0];
        inp2      = slot_val[1];
        inp3      = slot_val[2];
        inp4      = slot_val[3];
        inp1_dest = slot_dest[0];
        inp2_dest = slot_dest[1];
        inp3_dest = slot_dest[2];
        inp4_dest = slot_dest[3];
    endtask

    task automatic clear_instr();
        valid_in    = 1'b0;
        is_reg      = '0;
        is_seg      = '0;
        is_mem      = '0;
        far_xfer    = 1'b0;
        br_taken_in = 1'b0;
    endtask

    // present one instruction and hold it until writeback takes it
    task automatic issue(input wb_size_t size, input logic far);
        int tries;
        int s;
        int low;
        tries       = 0;
        low         = -1;
        inp_size    = size;
        far_xfer    = far;
        br_taken_in = far;
        valid_in    = 1'b1;
        #1;
        while (!valid_out && tries < wait_limit) begin
            @(negedge clk);
            #1;
            tries++;
        end
        if (!valid_out) begin
            timeout_failure("instruction never accepted, valid_out stayed low");
        end else begin
            for (s = 0; s < `WB_SLOTS; s++) begin
                if (is_mem[s] && low < 0) begin
                    low = s;
                end
            end
            if (low >= 0) begin   // lowest memory slot is stored
                exp_addr.push_back(slot_dest[low]);
                exp_data.push_back(slot_val[low]);
                exp_size.push_back(far ? 2'd3 : size);
            end
        end
        @(negedge clk);
        clear_instr();
    endtask

    task automatic hold_stalled(input wb_size_t size);
        inp_size = size;
        valid_in = 1'b1;
        repeat (2) begin
            #1;
            if (stall !== 1'b1) report_mismatch("stall", stall, 1);
            if (valid_out !== 1'b0) report_mismatch("valid_out", valid_out, 0);
            @(negedge clk);
        end
        clear_instr();
    endtask

    task automatic pop_head();
        int       tries;
        wb_addr_t want_addr;
        wb_data_t want_data;
        wb_size_t want_size;
        tries = 0;
        while (mem_req !== 1'b1 && tries < wait_limit) begin
            @(negedge clk);
            tries++;
        end
        if (mem_req !== 1'b1) begin
            timeout_failure("mem_req never rose for a pending store");
        end else if (exp_addr.size() == 0) begin
            errors++;
            test_errors++;
            $display("memory request at %0t with no store pending", $time);
        end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            want_size = exp_size.pop_front();
            if (mem_req_addr !== want_addr) report_mismatch("mem_req_addr", mem_req_addr, want_addr);
            if (mem_req_data !== want_data) report_mismatch("mem_req_data", mem_req_data, want_data);
            if (mem_req_size !== want_size) report_mismatch("mem_req_size", mem_req_size, want_size);
            mem_ack = 1'b1;
            @(negedge clk);
            mem_ack = 1'b0;
            if (wbaq_full !== 1'b0) report_mismatch("wbaq_full", wbaq_full, 0);
        end
    endtask

    task automatic drain_queue();
        int gap;
        while (exp_addr.size() > 0 && !abort) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
            pop_head();
        end
        if (mem_req !== 1'b0) report_mismatch("mem_req", mem_req, 0);
    endtask

    task automatic check_regs(input logic is_gpr);
        rd_gpr_idx = fld[0][2:0];
        rd_seg_idx = fld[0][2:0];
        #1;
        if (is_gpr && rd_gpr_data !== fld[1][31:0]) begin
            report_mismatch("rd_gpr_data", rd_gpr_data, fld[1]);
        end
        if (!is_gpr && rd_seg_data !== fld[1][15:0]) begin
            report_mismatch("rd_seg_data", rd_seg_data, fld[1]);
        end
    endtask

    task automatic check_idle();
        is_mem = '1;   // a store is waiting, only a full queue may stall it
        #1;
        if (mem_req !== 1'b0) report_mismatch("mem_req", mem_req, 0);
        if (wbaq_full !== 1'b0) report_mismatch("wbaq_full", wbaq_full, 0);
        if (stall !== 1'b0) report_mismatch("stall", stall, 0);
        is_mem = '0;
    endtask

    task automatic check_branch();
        br_valid_in   = fld[0][0];
        br_taken_in   = fld[1][0];
        br_correct_in = fld[2][0];
        far_xfer      = fld[3][0];
        br_fip_in     = fld[4][31:0];
        br_fip_p1_in  = fld[5][31:0];
        eip_in        = fld[6][31:0];
        #1;
        if (new_eip !== fld[7][31:0]) report_mismatch("new_eip", new_eip, fld[7]);
        if (fip_e !== fld[8][31:0]) report_mismatch("fip_e", fip_e, fld[8]);
        if (fip_o !== fld[9][31:0]) report_mismatch("fip_o", fip_o, fld[9]);
        if (is_resteer !== fld[10][0]) report_mismatch("is_resteer", is_resteer, fld[10]);
        if (fld[3][0] && cs_out !== slot_val[0][47:32]) begin   // selector from slot 1
            report_mismatch("cs_out", cs_out, slot_val[0][47:32]);
        end
        br_valid_in   = 1'b0;   // cleared before the edge so cs is left alone
        br_taken_in   = 1'b0;
        br_correct_in = 1'b0;
        far_xfer      = 1'b0;
    endtask

    task automatic check_ie();
        ie_in        = fld[0][0];
        ie_type_in   = fld[1][3:0];
        interrupt_in = fld[2][0];
        #1;
        if (final_ie_val !== fld[3][0]) report_mismatch("final_ie_val", final_ie_val, fld[3]);
        if (final_ie_type !== fld[4][3:0]) report_mismatch("final_ie_type", final_ie_type, fld[4]);
        ie_in        = 1'b0;
        interrupt_in = 1'b0;
    endtask

    task automatic close_test();
        if (tests > 0) begin
            if (test_errors == 0) begin
                $display("test %0s: pass", test_name);
            end else begin
                $display("test %0s: fail, %0d errors", test_name, test_errors);
                failed_tests++;
            end
        end
    endtask

    initial begin
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [8*8-1:0]   cmd;
        clk           = 1'b0;
        reset         = 1'b1;
        mem_ack       = 1'b0;
        inp_size      = '0;
        br_valid_in   = 1'b0;
        br_correct_in = 1'b0;
        br_fip_in     = '0;
        br_fip_p1_in  = '0;
        eip_in        = '0;
        ie_in         = 1'b0;
        ie_type_in    = '0;
        interrupt_in  = 1'b0;
        rd_gpr_idx    = '0;
        rd_seg_idx    = '0;
        clear_instr();
        for (int i = 1; i <= `WB_SLOTS; i++) begin
            set_slot(i, 3'b000, '0, '0);
        end
        seed         = 32'hdd14fbf2;
        errors       = 0;
        test_errors  = 0;
        tests        = 0;
        failed_tests = 0;
        abort        = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("bench/writeback_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/writeback_testdata.txt");
            errors++;
            abort = 1'b1;
        end
        while (!abort && !$feof(fd)) begin
            line = '0;
            cmd  = '0;
            n    = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", cmd) == 1 && cmd != "#") begin
                if (cmd == "test") begin
                    close_test();
                    n = $sscanf(line, "%s %s", cmd, test_name);
                    tests++;
                    test_errors = 0;
                end else begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", cmd, fld[0],
                                fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                                fld[8], fld[9], fld[10]);
                    @(negedge clk);
                    case (cmd)
                        "slot":  set_slot(int'(fld[0][2:0]), fld[1][2:0], fld[2][31:0], fld[3]);
                        "go":    issue(fld[0][1:0], fld[1][0]);
                        "hold":  hold_stalled(fld[0][1:0]);
                        "gpr":   check_regs(1'b1);
                        "seg":   check_regs(1'b0);
                        "ack":   pop_head();
                        "drain": drain_queue();
                        "idle":  check_idle();
                        "br":    check_branch();
                        "ie":    check_ie();
                        default: begin
                            $display("unknown command in test data: %0s", cmd);
                            errors++;
                        end
                    endcase
                end
            end
        end
        close_test();
        if (fd != 0) $fclose(fd);
        if (tests == 0) begin
            $display("no tests found in the test data");
            errors++;
        end

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/writeback_testdata.txt */
# slot n tag(1 reg 2 seg 4 mem) dest value | go size far | hold size | gpr/seg idx exp | ack | drain
# br valid taken correct far fip fip_p1 eip exp_eip exp_fip_e exp_fip_o exp_resteer | ie ie type irq val type
test after_reset
idle
gpr 2 0
seg 1 0
test sized_regs
slot 1 1 3 00000000a1b2c3d4
go 2 0
gpr 3 a1b2c3d4
slot 1 1 3 ee
go 0 0
gpr 3 a1b2c3ee
slot 1 1 3 5566
slot 3 1 3 7788
go 1 0
gpr 3 a1b27788
test seg_far
slot 2 2 4 11a2beef
go 2 0
seg 4 beef
slot 1 0 0 0000f00d00401000
slot 2 4 2000 cafef00d
br 1 1 1 1 00500000 00500010 0 00401000 00500000 00500010 0
go 2 1
seg 1 f00d
drain
test store_order
slot 2 4 1000 1111
slot 3 4 1004 2222
go 2 0
slot 1 4 1008 3333
slot 4 4 100c 4444
go 1 0
slot 3 4 1010 5555
go 0 0
drain
test back_pressure
slot 1 4 3000 b0
go 2 0
slot 1 4 3004 b1
go 2 0
slot 1 4 3008 b2
go 2 0
slot 1 4 300c b3
go 2 0
slot 1 4 3010 b4
slot 2 1 5 12121212
hold 2
gpr 5 0
slot 3 1 6 34343434
go 2 0
gpr 6 34343434
ack
slot 1 4 3010 b4
slot 2 1 5 12121212
go 2 0
gpr 5 12121212
drain
test branch
br 1 1 0 0 00401234 00401244 00400ff0 00401234 00401240 00401230 1
br 1 0 1 0 00402008 00402018 00400ff0 00400ff0 00402000 00402010 0
br 0 1 0 0 0000ffff 0001000f 0 0000ffff 00010000 0000fff0 0
test exceptions
ie 0 5 0 0 5
ie 1 e 0 1 6
ie 0 3 1 1 b
ie 1 f 1 1 f

/* hdl/wb_branch.sv */
`timescale 1ns/1ps

module wb_branch import wb_data_pkg::*; import wb_ctrl_pkg::*; (
    input  logic     br_valid_in,
    input  logic     br_taken_in,
    input  logic     br_correct_in,
    input  fip_t     br_fip_in,
    input  fip_t     br_fip_p1_in,
    input  fip_t     eip_in,
    input  logic     far_xfer,
    input  wb_data_t inp1,
    input  logic     ie_in,
    input  ie_type_t ie_type_in,
    input  logic     interrupt_in,
    output fip_t     new_eip,
    output fip_t     fip_e,
    output fip_t     fip_o,
    output logic     is_resteer,
    output seg_t     cs_out,
    output logic     cs_ld,
    output logic     final_ie_val,
    output ie_type_t final_ie_type
);

    fip_t target_eip;
    fip_t line_t;
    fip_t line_p1;

    // far transfer takes its target from slot 1 instead of the predictor
    assign target_eip = far_xfer ? inp1[31:0] : br_fip_in;
    assign new_eip    = br_taken_in ? target_eip : eip_in;

    assign line_t  = {br_fip_in[31:4], 4'h0};
    assign line_p1 = {br_fip_p1_in[31:4], 4'h0};

    // even bank gets whichever line has bit 4 clear
    assign fip_e = line_t[4] ? line_p1 : line_t;
    assign fip_o = line_t[4] ? line_t  : line_p1;

    assign is_resteer = br_valid_in & ~br_correct_in;

    assign cs_out = inp1[47:32];               // selector half of the far pointer
    assign cs_ld  = far_xfer & br_taken_in;

    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]};

endmodule

/* hdl/wb_ctrl_pkg.sv */
package wb_ctrl_pkg;

    // fetch pointer and instruction pointer
    typedef logic [31:0] fip_t;

    // exception type, bit 3 flags an external interrupt
    typedef logic [3:0]  ie_type_t;

    // occupancy of the write address queue
    typedef enum logic [1:0] {
        st_empty   = 2'd0,
        st_partial = 2'd1,
        st_full    = 2'd2
    } wbaq_state_t;

endpackage

/* hdl/wb_data_pkg.sv */
package wb_data_pkg;

    // raw slot result, wide enough for a far pointer
    typedef logic [63:0] wb_data_t;

    // memory address or slot destination
    typedef logic [31:0] wb_addr_t;

    // operand size: 0 byte, 1 word, 2 dword, 3 far 48-bit store
    typedef logic [1:0]  wb_size_t;

    // register file index
    typedef logic [2:0]  reg_idx_t;

    // segment selector
    typedef logic [15:0] seg_t;

endpackage

/* hdl/wb_defines.svh */
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// result slots carried by one instruction
`define WB_SLOTS    4

// pending stores in the write address queue
`define WBAQ_DEPTH  4

// architectural register files
`define GPR_COUNT   8     // eax .. edi
`define SEG_COUNT   8     // es, cs, ss, ds, fs, gs and two spare

`endif

/* hdl/wb_regfile.sv */
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_regfile import wb_data_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`WB_SLOTS-1:0] reg_ld,
    input  logic [`WB_SLOTS-1:0] seg_ld,
    input  wb_data_t             inp1,
    input  wb_data_t             inp2,
    input  wb_data_t             inp3,
    input  wb_data_t             inp4,
    input  reg_idx_t             dest1,
    input  reg_idx_t             dest2,
    input  reg_idx_t             dest3,
    input  reg_idx_t             dest4,
    input  wb_size_t             inp_size,
    input  logic                 cs_ld,
    input  seg_t                 cs_in,
    input  reg_idx_t             rd_gpr_idx,
    input  reg_idx_t             rd_seg_idx,
    output logic [31:0]          rd_gpr_data,
    output seg_t                 rd_seg_data
);

    localparam reg_idx_t cs_idx = 3'd1;

    logic [31:0] gpr      [`GPR_COUNT];
    seg_t        seg      [`SEG_COUNT];
    wb_data_t    slot_val [`WB_SLOTS];
    reg_idx_t    slot_idx [`WB_SLOTS];
    logic [31:0] wr_mask;

    function automatic logic [31:0] size_mask(input wb_size_t size);
        case (size)
            2'd0:    size_mask = 32'h0000_00ff;
            2'd1:    size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    endfunction

    assign slot_val[0] = inp1;
    assign slot_val[1] = inp2;
    assign slot_val[2] = inp3;
    assign slot_val[3] = inp4;
    assign slot_idx[0] = dest1;
    assign slot_idx[1] = dest2;
    assign slot_idx[2] = dest3;
    assign slot_idx[3] = dest4;

    assign wr_mask = size_mask(inp_size);   // one size for all slots

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                gpr[i] <= '0;
            end
            for (int i = 0; i < `SEG_COUNT; i++) begin
                seg[i] <= '0;
            end
        end else begin
            // later slots overwrite earlier ones on the same index
            for (int s = 0; s < `WB_SLOTS; s++) begin
                if (reg_ld[s]) begin
                    gpr[slot_idx[s]] <= (gpr[slot_idx[s]] & ~wr_mask) |
                                        (slot_val[s][31:0] & wr_mask);
                end
                if (seg_ld[s]) begin
                    seg[slot_idx[s]] <= slot_val[s][15:0];
                end
            end
            if (cs_ld) begin
                seg[cs_idx] <= cs_in;        // far transfer reloads cs
            end
        end
    end

    assign rd_gpr_data = gpr[rd_gpr_idx];
    assign rd_seg_data = seg[rd_seg_idx];

endmodule

/* hdl/wb_steer.sv */
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_steer import wb_data_pkg::*; (
    input  logic                 valid_in,
    input  wb_data_t             inp1,
    input  wb_data_t             inp2,
    input  wb_data_t             inp3,
    input  wb_data_t             inp4,
    input  wb_addr_t             inp1_dest,
    input  wb_addr_t             inp2_dest,
    input  wb_addr_t             inp3_dest,
    input  wb_addr_t             inp4_dest,
    input  logic [`WB_SLOTS-1:0] is_reg,
    input  logic [`WB_SLOTS-1:0] is_seg,
    input  logic [`WB_SLOTS-1:0] is_mem,
    input  wb_size_t             inp_size,
    input  logic                 far_xfer,
    input  logic                 wbaq_full,
    output logic                 valid_out,
    output logic [`WB_SLOTS-1:0] reg_ld,
    output logic [`WB_SLOTS-1:0] seg_ld,
    output logic                 mem_ld,
    output wb_addr_t             mem_addr,
    output wb_data_t             mem_data,
    output wb_size_t             mem_size,
    output logic                 stall
);

    wb_data_t slot_val  [`WB_SLOTS];
    wb_addr_t slot_dest [`WB_SLOTS];
    logic     any_mem;

    assign slot_val[0]  = inp1;
    assign slot_val[1]  = inp2;
    assign slot_val[2]  = inp3;
    assign slot_val[3]  = inp4;
    assign slot_dest[0] = inp1_dest;
    assign slot_dest[1] = inp2_dest;
    assign slot_dest[2] = inp3_dest;
    assign slot_dest[3] = inp4_dest;

    assign any_mem   = |is_mem;
    assign stall     = wbaq_full & any_mem;   // queue cannot take the store
    assign valid_out = valid_in & ~stall;

    assign reg_ld = is_reg & {`WB_SLOTS{valid_out}};
    assign seg_ld = is_seg & {`WB_SLOTS{valid_out}};
    assign mem_ld = any_mem & valid_out;

    // one store per instruction, lowest memory slot wins
    always_comb begin
        mem_addr = '0;
        mem_data = '0;
        for (int s = `WB_SLOTS - 1; s >= 0; s--) begin
            if (is_mem[s]) begin
                mem_addr = slot_dest[s];
                mem_data = slot_val[s];
            end
        end
    end

    assign mem_size = far_xfer ? 2'd3 : inp_size;   // far pointer store is 48 bits

endmodule

/* hdl/wbaq.sv */
`timescale 1ns/1ps
`include "wb_defines.svh"

module wbaq import wb_data_pkg::*; import wb_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_ld,
    input  wb_addr_t mem_addr,
    input  wb_data_t mem_data,
    input  wb_size_t mem_size,
    input  logic     mem_ack,
    output logic     wbaq_full,
    output logic     mem_req,
    output wb_addr_t mem_req_addr,
    output wb_data_t mem_req_data,
    output wb_size_t mem_req_size
);

    localparam int               ptr_w    = $clog2(`WBAQ_DEPTH);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`WBAQ_DEPTH - 1);

    wb_addr_t         addr_q [`WBAQ_DEPTH];
    wb_data_t         data_q [`WBAQ_DEPTH];
    wb_size_t         size_q [`WBAQ_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr_nxt;
    logic [ptr_w-1:0] rd_ptr_nxt;
    wbaq_state_t      state;
    wbaq_state_t      state_nxt;
    logic             push;
    logic             pop;

    assign pop  = mem_ack && (state != st_empty);
    assign push = mem_ld && ((state != st_full) || pop);

    assign wr_ptr_nxt = (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_nxt = (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;

    always_comb begin
        case ({push, pop})
            2'b10:   state_nxt = (wr_ptr_nxt == rd_ptr) ? st_full : st_partial;
            2'b01:   state_nxt = (rd_ptr_nxt == wr_ptr) ? st_empty : st_partial;
            default: state_nxt = state;      // idle, or push and pop together
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_empty;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            state <= state_nxt;
            if (push) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= mem_addr;
            data_q[wr_ptr] <= mem_data;
            size_q[wr_ptr] <= mem_size;
        end
    end

    assign mem_req      = (state != st_empty);
    assign wbaq_full    = (state == st_full);
    assign mem_req_addr = addr_q[rd_ptr];
    assign mem_req_data = data_q[rd_ptr];
    assign mem_req_size = size_q[rd_ptr];

    // memory side only acknowledges an outstanding request
    a_ack_with_req: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> mem_req)
        else $error("mem_ack with empty write address queue");

    // steering must hold stores back while the queue is full
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (mem_ld && wbaq_full) |-> mem_ack)
        else $error("store pushed into full write address queue");

endmodule

/* hdl/writeback_top.sv */
`timescale 1ns/1ps
`include "wb_defines.svh"

module writeback_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    valid_in,
    input  wb_data_pkg::wb_data_t   inp1,
    input  wb_data_pkg::wb_data_t   inp2,
    input  wb_data_pkg::wb_data_t   inp3,
    input  wb_data_pkg::wb_data_t   inp4,
    input  wb_data_pkg::wb_addr_t   inp1_dest,
    input  wb_data_pkg::wb_addr_t   inp2_dest,
    input  wb_data_pkg::wb_addr_t   inp3_dest,
    input  wb_data_pkg::wb_addr_t   inp4_dest,
    input  logic [`WB_SLOTS-1:0]    is_reg,
    input  logic [`WB_SLOTS-1:0]    is_seg,
    input  logic [`WB_SLOTS-1:0]    is_mem,
    input  wb_data_pkg::wb_size_t   inp_size,
    input  logic                    far_xfer,
    input  logic                    br_valid_in,
    input  logic                    br_taken_in,
    input  logic                    br_correct_in,
    input  wb_ctrl_pkg::fip_t       br_fip_in,
    input  wb_ctrl_pkg::fip_t       br_fip_p1_in,
    input  wb_ctrl_pkg::fip_t       eip_in,
    input  logic                    ie_in,
    input  wb_ctrl_pkg::ie_type_t   ie_type_in,
    input  logic                    interrupt_in,
    input  logic                    mem_ack,
    input  wb_data_pkg::reg_idx_t   rd_gpr_idx,
    input  wb_data_pkg::reg_idx_t   rd_seg_idx,
    output logic                    valid_out,
    output logic                    stall,
    output logic                    wbaq_full,
    output logic                    mem_req,
    output wb_data_pkg::wb_addr_t   mem_req_addr,
    output wb_data_pkg::wb_data_t   mem_req_data,
    output wb_data_pkg::wb_size_t   mem_req_size,
    output wb_ctrl_pkg::fip_t       new_eip,
    output wb_ctrl_pkg::fip_t       fip_e,
    output wb_ctrl_pkg::fip_t       fip_o,
    output logic                    is_resteer,
    output wb_data_pkg::seg_t       cs_out,
    output logic                    final_ie_val,
    output wb_ctrl_pkg::ie_type_t   final_ie_type,
    output logic [31:0]             rd_gpr_data,
    output wb_data_pkg::seg_t       rd_seg_data
);

    logic [`WB_SLOTS-1:0]  reg_ld;
    logic [`WB_SLOTS-1:0]  seg_ld;
    logic                  mem_ld;
    wb_data_pkg::wb_addr_t mem_addr;
    wb_data_pkg::wb_data_t mem_data;
    wb_data_pkg::wb_size_t mem_size;
    logic                  cs_ld;

    wb_steer u_steer (
        .valid_in  (valid_in),
        .inp1      (inp1),
        .inp2      (inp2),
        .inp3      (inp3),
        .inp4      (inp4),
        .inp1_dest (inp1_dest),
        .inp2_dest (inp2_dest),
        .inp3_dest (inp3_dest),
        .inp4_dest (inp4_dest),
        .is_reg    (is_reg),
        .is_seg    (is_seg),
        .is_mem    (is_mem),
        .inp_size  (inp_size),
        .far_xfer  (far_xfer),
        .wbaq_full (wbaq_full),
        .valid_out (valid_out),
        .reg_ld    (reg_ld),
        .seg_ld    (seg_ld),
        .mem_ld    (mem_ld),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_size  (mem_size),
        .stall     (stall)
    );

    wb_branch u_branch (
        .br_valid_in   (br_valid_in),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .br_fip_in     (br_fip_in),
        .br_fip_p1_in  (br_fip_p1_in),
        .eip_in        (eip_in),
        .far_xfer      (far_xfer),
        .inp1          (inp1),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .new_eip       (new_eip),
        .fip_e         (fip_e),
        .fip_o         (fip_o),
        .is_resteer    (is_resteer),
        .cs_out        (cs_out),
        .cs_ld         (cs_ld),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    wb_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .reg_ld      (reg_ld),
        .seg_ld      (seg_ld),
        .inp1        (inp1),
        .inp2        (inp2),
        .inp3        (inp3),
        .inp4        (inp4),
        .dest1       (inp1_dest[2:0]),   // register index sits in the low bits
        .dest2       (inp2_dest[2:0]),
        .dest3       (inp3_dest[2:0]),
        .dest4       (inp4_dest[2:0]),
        .inp_size    (inp_size),
        .cs_ld       (cs_ld),
        .cs_in       (cs_out),
        .rd_gpr_idx  (rd_gpr_idx),
        .rd_seg_idx  (rd_seg_idx),
        .rd_gpr_data (rd_gpr_data),
        .rd_seg_data (rd_seg_data)
    );

    wbaq u_wbaq (
        .clk          (clk),
        .reset        (reset),
        .mem_ld       (mem_ld),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_size     (mem_size),
        .mem_ack      (mem_ack),
        .wbaq_full    (wbaq_full),
        .mem_req      (mem_req),
        .mem_req_addr (mem_req_addr),
        .mem_req_data (mem_req_data),
        .mem_req_size (mem_req_size)
    );

endmodule

/* writeback_top.f */
+incdir+hdl
hdl/wb_data_pkg.sv
hdl/wb_ctrl_pkg.sv
hdl/wb_steer.sv
hdl/wb_branch.sv
hdl/wb_regfile.sv
hdl/wbaq.sv
hdl/writeback_top.sv
bench/writeback_tb.sv
